// File: source/mipsPkg.sv
package mipsPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

	typedef enum logic [1:0] {pcSequential, pcJump, pcBranch} pcSelT;

	typedef enum logic [1:0] {fwdRegister, fwdMemory, fwdWriteback} fwdSelT;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;

	localparam int   regCount   = 32;
	localparam int   immBits    = 16;
	localparam int   targetBits = 26;
	localparam wordT instrBytes = 32'd4;
	// All-zero word decodes as an R-type with no valid function, so it writes nothing
	localparam wordT nopInstr   = 32'h0000_0000;

endpackage

// File: source/stageIfs.sv
`timescale 1ns/1ps

// Decode to execute boundary
interface idExIf
	import mipsPkg::*;
();
	logic    regWrite;
	logic    memRead;
	logic    memWrite;
	logic    memToReg;
	logic    isBranch;
	aluOpT   aluOp;
	logic    useImm;
	wordT    a;
	wordT    b;
	wordT    imm;
	wordT    pc4;
	regAddrT rs;
	regAddrT rt;
	regAddrT dest;

	modport source (
		output regWrite, memRead, memWrite, memToReg, isBranch,
		output aluOp, useImm, a, b, imm, pc4, rs, rt, dest
	);
	modport sink (
		input regWrite, memRead, memWrite, memToReg, isBranch,
		input aluOp, useImm, a, b, imm, pc4, rs, rt, dest
	);
endinterface

// Execute to memory boundary
interface exMemIf
	import mipsPkg::*;
();
	logic    regWrite;
	logic    memRead;
	logic    memWrite;
	logic    memToReg;
	regAddrT dest;
	wordT    result;
	wordT    storeData;

	modport source (output regWrite, memRead, memWrite, memToReg, dest, result, storeData);
	modport sink (input regWrite, memRead, memWrite, memToReg, dest, result, storeData);
endinterface

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile
	import mipsPkg::*;
(
	input  logic    CLK,
	input  logic    reset,
	input  regAddrT rs,
	input  regAddrT rt,
	output wordT    readA,
	output wordT    readB,
	input  logic    wbEn,
	input  regAddrT wbReg,
	input  wordT    wbData
);

	wordT regs [regCount];
	logic writing;

	assign writing = wbEn && (wbReg != '0);

	// Same-cycle write is visible to the reader
	function automatic wordT readPort(regAddrT addr);
		if (writing && (wbReg == addr))
			return wbData;
		return regs[addr];
	endfunction

	assign readA = readPort(rs);
	assign readB = readPort(rt);

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (writing) begin
			regs[wbReg] <= wbData;
		end
	end

endmodule

// File: source/fetchStage.sv
`timescale 1ns/1ps

module fetchStage
	import mipsPkg::*;
(
	input  logic  CLK,
	input  logic  reset,
	input  wordT  startPc,
	input  logic  stall,
	input  logic  flushDecode,
	input  pcSelT pcSel,
	input  wordT  jumpTarget,
	input  wordT  branchTarget,
	input  wordT  instr,
	output wordT  instrAddr,
	output wordT  decInstr,
	output wordT  decPc4
);

	wordT pc, pc4, nextPc;

	assign pc4       = pc + instrBytes;
	assign instrAddr = pc;

	always_comb begin
		case (pcSel)
			pcJump:   nextPc = jumpTarget;
			pcBranch: nextPc = branchTarget;
			default:  nextPc = pc4;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset)
			pc <= startPc;
		else if (!stall)
			pc <= nextPc;
	end

	// Flush wins over stall so a taken branch always squashes fetch
	always_ff @(posedge CLK) begin
		if (reset || flushDecode)
			decInstr <= nopInstr;
		else if (!stall)
			decInstr <= instr;
	end

	always_ff @(posedge CLK) begin
		if (!stall)
			decPc4 <= pc4;
	end

endmodule

// File: source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
	import mipsPkg::*;
(
	input  logic    CLK,
	input  logic    reset,
	input  wordT    decInstr,
	input  wordT    decPc4,
	input  logic    bubble,
	input  logic    wbEn,
	input  regAddrT wbReg,
	input  wordT    wbData,
	output logic    isJump,
	output wordT    jumpTarget,
	output regAddrT rs,
	output regAddrT rt,
	output logic    usesRt,
	idExIf.source   ex
);

	opcodeT  opcode;
	functT   funct;
	regAddrT rd, dest;
	wordT    readA, readB, immExt;
	aluOpT   aluOp;
	logic    regWrite, memRead, memWrite, memToReg, isBranch, useImm;

	assign opcode = opcodeT'(decInstr[31:26]);
	assign funct  = functT'(decInstr[5:0]);
	assign rs     = decInstr[25:21];
	assign rt     = decInstr[20:16];
	assign rd     = decInstr[15:11];

	assign immExt     = {{(32 - immBits){decInstr[immBits-1]}}, decInstr[immBits-1:0]};
	assign jumpTarget = {decPc4[31:28], decInstr[targetBits-1:0], 2'b00};

	registerFile registerFile_i (
		.CLK(CLK), .reset(reset), .rs(rs), .rt(rt), .readA(readA), .readB(readB),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
	);

	////////////////////////////////////////
	// Control decode
	////////////////////////////////////////
	always_comb begin
		regWrite = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		isBranch = 1'b0;
		isJump   = 1'b0;
		useImm   = 1'b0;
		usesRt   = 1'b0;
		aluOp    = aluAdd;
		dest     = rt;
		case (opcode)
			opRType: begin
				dest   = rd;
				usesRt = 1'b1;
				// Unknown functions (including the nop) write nothing
				regWrite = 1'b1;
				case (funct)
					fnAdd:   aluOp = aluAdd;
					fnSub:   aluOp = aluSub;
					fnAnd:   aluOp = aluAnd;
					fnOr:    aluOp = aluOr;
					fnSlt:   aluOp = aluSlt;
					default: regWrite = 1'b0;
				endcase
			end
			opAddi: begin
				regWrite = 1'b1;
				useImm   = 1'b1;
			end
			opLw: begin
				regWrite = 1'b1;
				memRead  = 1'b1;
				memToReg = 1'b1;
				useImm   = 1'b1;
			end
			opSw: begin
				memWrite = 1'b1;
				useImm   = 1'b1;
				usesRt   = 1'b1;
			end
			opBeq: begin
				isBranch = 1'b1;
				usesRt   = 1'b1;
				aluOp    = aluSub;
			end
			opJ:     isJump = 1'b1;
			default: ;
		endcase
	end

	// Enables of the decode/execute register, cleared for a bubble
	always_ff @(posedge CLK) begin
		if (reset || bubble) begin
			ex.regWrite <= 1'b0;
			ex.memRead  <= 1'b0;
			ex.memWrite <= 1'b0;
			ex.memToReg <= 1'b0;
			ex.isBranch <= 1'b0;
		end else begin
			ex.regWrite <= regWrite;
			ex.memRead  <= memRead;
			ex.memWrite <= memWrite;
			ex.memToReg <= memToReg;
			ex.isBranch <= isBranch;
		end
	end

	always_ff @(posedge CLK) begin
		ex.aluOp  <= aluOp;
		ex.useImm <= useImm;
		ex.a      <= readA;
		ex.b      <= readB;
		ex.imm    <= immExt;
		ex.pc4    <= decPc4;
		ex.rs     <= rs;
		ex.rt     <= rt;
		ex.dest   <= dest;
	end

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
	import mipsPkg::*;
(
	input  regAddrT rs,
	input  regAddrT rt,
	input  logic    usesRt,
	input  logic    isJump,
	input  logic    exMemRead,
	input  regAddrT exDest,
	input  logic    branchTaken,
	output logic    stall,
	output logic    bubble,
	output logic    flushDecode,
	output pcSelT   pcSel
);

	logic loadUse, takeJump;

	// Load in execute feeding the instruction in decode
	assign loadUse = exMemRead && (exDest != '0) &&
		((exDest == rs) || (usesRt && (exDest == rt)));

	assign takeJump = isJump && !loadUse;

	// Taken branch overrides everything younger
	assign stall       = loadUse && !branchTaken;
	assign bubble      = loadUse || branchTaken;
	assign flushDecode = branchTaken || takeJump;

	always_comb begin
		if (branchTaken)
			pcSel = pcBranch;
		else if (takeJump)
			pcSel = pcJump;
		else
			pcSel = pcSequential;
	end

endmodule

// File: source/executeStage.sv
`timescale 1ns/1ps

module executeStage
	import mipsPkg::*;
(
	input  logic    CLK,
	input  logic    reset,
	idExIf.sink     id,
	exMemIf.source  mem,
	input  logic    wbEn,
	input  regAddrT wbReg,
	input  wordT    wbData,
	output logic    branchTaken,
	output wordT    branchTarget,
	output logic    exMemRead,
	output regAddrT exDest
);

	fwdSelT selA, selB;
	wordT   opA, regB, opB, result;

	// Memory stage is the younger producer so it takes priority
	function automatic fwdSelT fwdSource(regAddrT src, logic memWr, regAddrT memDest,
			logic wbWr, regAddrT wbDest);
		if (src == '0)
			return fwdRegister;
		if (memWr && (memDest == src))
			return fwdMemory;
		if (wbWr && (wbDest == src))
			return fwdWriteback;
		return fwdRegister;
	endfunction

	function automatic wordT operandMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
		case (sel)
			fwdMemory:    return memVal;
			fwdWriteback: return wbVal;
			default:      return regVal;
		endcase
	endfunction

	assign selA = fwdSource(id.rs, mem.regWrite, mem.dest, wbEn, wbReg);
	assign selB = fwdSource(id.rt, mem.regWrite, mem.dest, wbEn, wbReg);
	assign opA  = operandMux(selA, id.a, mem.result, wbData);
	assign regB = operandMux(selB, id.b, mem.result, wbData);
	assign opB  = id.useImm ? id.imm : regB;

	////////////////////////////////////////
	// ALU and branch
	////////////////////////////////////////
	always_comb begin
		case (id.aluOp)
			aluSub:  result = opA - opB;
			aluAnd:  result = opA & opB;
			aluOr:   result = opA | opB;
			aluSlt:  result = {31'd0, $signed(opA) < $signed(opB)};
			default: result = opA + opB;
		endcase
	end

	assign branchTaken  = id.isBranch && (opA == regB);
	assign branchTarget = id.pc4 + (id.imm << 2);
	assign exMemRead    = id.memRead;
	assign exDest       = id.dest;

	always_ff @(posedge CLK) begin
		if (reset) begin
			mem.regWrite <= 1'b0;
			mem.memRead  <= 1'b0;
			mem.memWrite <= 1'b0;
			mem.memToReg <= 1'b0;
		end else begin
			mem.regWrite <= id.regWrite;
			mem.memRead  <= id.memRead;
			mem.memWrite <= id.memWrite;
			mem.memToReg <= id.memToReg;
		end
	end

	// Store data leaves already forwarded
	always_ff @(posedge CLK) begin
		mem.dest      <= id.dest;
		mem.result    <= result;
		mem.storeData <= regB;
	end

endmodule

// File: source/memoryStage.sv
`timescale 1ns/1ps

module memoryStage
	import mipsPkg::*;
#(
	parameter int memAddrBits = 6
) (
	input  logic    CLK,
	input  logic    reset,
	exMemIf.sink    mem,
	output logic    wbEn,
	output regAddrT wbReg,
	output wordT    wbData
);

	wordT dataMem [2**memAddrBits];

	logic [memAddrBits-1:0] addr;
	wordT                   loadWord, aluWord;
	logic                   wbMemToReg;

	// Byte address in, word index out
	assign addr = mem.result[memAddrBits+1:2];

	always_ff @(posedge CLK) begin
		if (mem.memWrite)
			dataMem[addr] <= mem.storeData;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wbEn       <= 1'b0;
			wbMemToReg <= 1'b0;
		end else begin
			wbEn       <= mem.regWrite;
			wbMemToReg <= mem.memToReg;
		end
	end

	always_ff @(posedge CLK) begin
		wbReg   <= mem.dest;
		aluWord <= mem.result;
		if (mem.memRead)
			loadWord <= dataMem[addr];
	end

	// Write-back select
	assign wbData = wbMemToReg ? loadWord : aluWord;

endmodule

// File: source/pipelineCpu.sv
`timescale 1ns/1ps

module pipelineCpu
	import mipsPkg::*;
#(
	parameter int memAddrBits = 6
) (
	input  logic    CLK,
	input  logic    reset,
	input  wordT    startPc,
	output wordT    instrAddr,
	input  wordT    instr,
	output logic    wbEn,
	output regAddrT wbReg,
	output wordT    wbData
);

	////////////////////////////////////////
	// Inter-stage wiring
	////////////////////////////////////////
	logic    stall, bubble, flushDecode;
	pcSelT   pcSel;
	wordT    jumpTarget, branchTarget;
	logic    branchTaken, isJump, usesRt, exMemRead;
	wordT    decInstr, decPc4;
	regAddrT rs, rt, exDest;

	idExIf  idEx ();
	exMemIf exMem ();

	fetchStage fetchStage_i (
		.CLK(CLK), .reset(reset), .startPc(startPc), .stall(stall),
		.flushDecode(flushDecode), .pcSel(pcSel), .jumpTarget(jumpTarget),
		.branchTarget(branchTarget), .instr(instr), .instrAddr(instrAddr),
		.decInstr(decInstr), .decPc4(decPc4)
	);

	decodeStage decodeStage_i (
		.CLK(CLK), .reset(reset), .decInstr(decInstr), .decPc4(decPc4),
		.bubble(bubble), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.isJump(isJump), .jumpTarget(jumpTarget), .rs(rs), .rt(rt),
		.usesRt(usesRt), .ex(idEx.source)
	);

	hazardUnit hazardUnit_i (
		.rs(rs), .rt(rt), .usesRt(usesRt), .isJump(isJump),
		.exMemRead(exMemRead), .exDest(exDest), .branchTaken(branchTaken),
		.stall(stall), .bubble(bubble), .flushDecode(flushDecode), .pcSel(pcSel)
	);

	executeStage executeStage_i (
		.CLK(CLK), .reset(reset), .id(idEx.sink), .mem(exMem.source),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.exMemRead(exMemRead), .exDest(exDest)
	);

	memoryStage #(.memAddrBits(memAddrBits)) memoryStage_i (
		.CLK(CLK), .reset(reset), .mem(exMem.sink),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
	);

endmodule

// File: tb/cpuTbProgram.svh
`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

wordT  imem     [imemWords];
string progTest [imemWords];
int    progLen = 0;
string section;
wordT  refRegs  [32];
wordT  refMem   [wordT];

function automatic wordT rTypeWord(functT fn, regAddrT rd, regAddrT rs, regAddrT rt);
	return {opRType, rs, rt, rd, 5'd0, fn};
endfunction

function automatic wordT immWord(opcodeT op, regAddrT rt, regAddrT rs, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// Absolute target from a program index
function automatic wordT jumpWord(int index);
	wordT target;
	target = bootPc + 32'(index * 4);
	return {opJ, target[27:2]};
endfunction

task automatic emit(wordT w);
	imem[progLen]     = w;
	progTest[progLen] = section;
	progLen++;
endtask

task automatic buildProgram();
	logic [15:0] r1, r2, r3;
	r1 = 16'($urandom());
	r2 = 16'($urandom());
	r3 = 16'($urandom());
	section = "aluForwarding";
	emit(immWord(opAddi, 5'd1, 5'd0, r1));
	emit(immWord(opAddi, 5'd2, 5'd0, r2));
	emit(rTypeWord(fnAdd, 5'd3, 5'd1, 5'd2));
	emit(rTypeWord(fnSub, 5'd4, 5'd3, 5'd1));
	emit(rTypeWord(fnAnd, 5'd5, 5'd4, 5'd3));
	emit(rTypeWord(fnOr, 5'd6, 5'd5, 5'd4));
	emit(rTypeWord(fnSlt, 5'd7, 5'd4, 5'd6));
	emit(immWord(opAddi, 5'd8, 5'd7, r3));
	emit(rTypeWord(fnSlt, 5'd9, 5'd6, 5'd5));
	section = "loadStore";
	emit(immWord(opSw, 5'd3, 5'd0, 16'd8));
	emit(immWord(opLw, 5'd10, 5'd0, 16'd8));
	emit(rTypeWord(fnAdd, 5'd11, 5'd10, 5'd2));
	emit(immWord(opLw, 5'd12, 5'd0, 16'd8));
	// Store data depends on the load just before it
	emit(immWord(opSw, 5'd12, 5'd0, 16'd16));
	emit(immWord(opLw, 5'd13, 5'd0, 16'd16));
	emit(rTypeWord(fnOr, 5'd14, 5'd13, 5'd1));
	section = "branch";
	emit(immWord(opBeq, 5'd1, 5'd1, 16'd2));
	emit(immWord(opAddi, 5'd15, 5'd0, 16'd1));
	emit(immWord(opAddi, 5'd16, 5'd0, 16'd2));
	emit(immWord(opAddi, 5'd17, 5'd0, 16'd5));
	emit(immWord(opBeq, 5'd0, 5'd17, 16'd1));
	emit(immWord(opAddi, 5'd18, 5'd0, 16'd3));
	emit(immWord(opAddi, 5'd19, 5'd0, 16'd4));
	section = "jump";
	emit(jumpWord(progLen + 2));
	emit(immWord(opAddi, 5'd20, 5'd0, 16'd7));
	emit(immWord(opAddi, 5'd21, 5'd0, 16'd9));
	section = "zeroRegister";
	emit(immWord(opAddi, 5'd0, 5'd0, 16'd123));
	emit(rTypeWord(fnAdd, 5'd22, 5'd0, 5'd0));
	emit(rTypeWord(fnAdd, 5'd23, 5'd0, 5'd1));
	// Parks the program in a jump to itself
	section = "halt";
	emit(jumpWord(progLen));
endtask

task automatic runReference();
	wordT    w, a, b, imm, val, pc, jt;
	int      idx, steps;
	logic    writes, halted;
	regAddrT dst;
	foreach (refRegs[i])
		refRegs[i] = '0;
	expCount = 0;
	steps    = 0;
	halted   = 1'b0;
	pc       = bootPc;
	while (!halted) begin
		idx = int'((pc - bootPc) >> 2);
		if (idx < 0 || idx >= progLen || steps > 8 * imemWords) begin
			halted = 1'b1;
		end else begin
			w      = imem[idx];
			a      = refRegs[w[25:21]];
			b      = refRegs[w[20:16]];
			imm    = {{16{w[15]}}, w[15:0]};
			dst    = w[20:16];
			writes = 1'b0;
			val    = '0;
			pc     = pc + 32'd4;
			steps++;
			case (w[31:26])
				opRType: begin
					dst    = w[15:11];
					writes = 1'b1;
					case (w[5:0])
						fnAdd:   val = a + b;
						fnSub:   val = a - b;
						fnAnd:   val = a & b;
						fnOr:    val = a | b;
						fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				opAddi: begin
					writes = 1'b1;
					val    = a + imm;
				end
				opLw: begin
					writes = 1'b1;
					val    = refMem[(a + imm) >> 2];
				end
				opSw:  refMem[(a + imm) >> 2] = b;
				opBeq: if (a == b) pc = pc + (imm << 2);
				opJ: begin
					jt     = {pc[31:28], w[25:0], 2'b00};
					halted = (jt == pc - 32'd4);
					pc     = jt;
				end
				default: ;
			endcase
			// r0 writes still retire but leave the register at zero
			if (writes) begin
				expReg[expCount]  = dst;
				expData[expCount] = val;
				expTest[expCount] = progTest[idx];
				expCount++;
				if (dst != '0)
					refRegs[dst] = val;
			end
		end
	end
endtask

`endif

// File: tb/cpuTb.sv
`timescale 1ns/1ps

module cpuTb
	import mipsPkg::*;
();

	localparam wordT bootPc    = 32'h0000_0040;
	localparam int   imemWords = 64;
	localparam int   maxWrites = 64;

	logic    CLK;
	logic    reset;
	wordT    startPc;
	wordT    instrAddr;
	wordT    instr;
	logic    wbEn;
	regAddrT wbReg;
	wordT    wbData;

	// Expected write-back sequence
	regAddrT expReg  [maxWrites];
	wordT    expData [maxWrites];
	string   expTest [maxWrites];
	int      expCount = 0;

	int   wbIdx        = 0;
	int   cycle        = 0;
	int   fetchIdx;
	int   valueErrors  = 0;
	int   otherErrors  = 0;
	logic programReady = 1'b0;

	`include "cpuTbProgram.svh"

	pipelineCpu #(.memAddrBits(6)) pipelineCpu_i (
		.CLK(CLK), .reset(reset), .startPc(startPc), .instrAddr(instrAddr),
		.instr(instr), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Instruction memory, answers in the same cycle
	always_comb begin
		fetchIdx = int'((instrAddr - startPc) >> 2);
		if (fetchIdx >= 0 && fetchIdx < progLen)
			instr = imem[fetchIdx];
		else
			instr = '0;
	end

	always @(posedge CLK) begin
		cycle <= cycle + 1;
		if (!reset && wbEn)
			wbIdx <= wbIdx + 1;
	end

	task automatic reportMismatch(string test, string field, wordT expected, wordT actual);
		valueErrors++;
		$display("** Error [%s] %s: expected %h, actual %h", test, field, expected, actual);
	endtask

	task automatic finishRun();
		$display("Error count: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	resetQuiet: assert property (@(posedge CLK) (cycle == 2) |-> !wbEn)
		else begin
			otherErrors++;
			$display("A register write was reported right after reset");
		end

	resetFetch: assert property (@(posedge CLK) (cycle == 2) |-> (instrAddr == startPc))
		else reportMismatch("reset", "instrAddr", $sampled(startPc), $sampled(instrAddr));

	extraWrite: assert property (@(posedge CLK) disable iff (reset) wbEn |-> (wbIdx < expCount))
		else begin
			otherErrors++;
			$display("Unexpected write to r%0d after the last expected write",
				$sampled(wbReg));
		end

	regMatch: assert property (@(posedge CLK) disable iff (reset)
			(wbEn && wbIdx < expCount) |-> (wbReg == expReg[wbIdx]))
		else reportMismatch(expTest[$sampled(wbIdx)],
			$sformatf("write %0d wbReg", $sampled(wbIdx)),
			32'(expReg[$sampled(wbIdx)]), 32'($sampled(wbReg)));

	dataMatch: assert property (@(posedge CLK) disable iff (reset)
			(wbEn && wbIdx < expCount) |-> (wbData == expData[wbIdx]))
		else reportMismatch(expTest[$sampled(wbIdx)],
			$sformatf("write %0d wbData", $sampled(wbIdx)),
			expData[$sampled(wbIdx)], $sampled(wbData));

	////////////////////////////////////////
	// Stimulus and watchdog
	////////////////////////////////////////
	initial begin
		void'($urandom(70285));
		reset   = 1'b1;
		startPc = bootPc;
		buildProgram();
		runReference();
		programReady = 1'b1;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		wait (wbIdx == expCount);
		// A few idle cycles to catch stray writes
		repeat (10) @(negedge CLK);
		finishRun();
	end

	initial begin
		wait (programReady);
		wait (!reset);
		repeat (progLen * 3 + 50) @(posedge CLK);
		otherErrors++;
		$display("Timeout: only %0d of %0d expected register writes retired",
			wbIdx, expCount);
		finishRun();
	end

endmodule

// File: sources.f
+incdir+tb
source/mipsPkg.sv
source/stageIfs.sv
source/registerFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/memoryStage.sv
source/pipelineCpu.sv
tb/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) tb/cpuTbProgram.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^Simulation PASSED$$'

clean:
	rm -rf $(OBJDIR)
